// File: hw/soc_params.svh
// address map, ram depth and display scan rate for the memory system
// SCAN_DIV is sized for simulation and must be at least 2
// the i/o page sits at 0x8000_0000, ram at 0x0000_0000
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

`define BRAM_AW      11            // ram word address bits, 2048 words
`define RAM_BASE_HI  19'h0_0000    // addr[31:13] of the boot ram

`define IO_BASE      24'h80_0000   // addr[31:8] of the i/o page
`define IO_AW        6             // word offset bits in the page
`define IO_LEDS      6'd0          // leds, read/write
`define IO_SWITCHES  6'd1          // switches, read only
`define IO_DISPLAY   6'd2          // display value, read/write

`define SCAN_DIV     16            // cycles per display digit

`endif

// File: hw/soc_pkg.sv
// enums shared by the memory system blocks
// the encodings of mem_size_t follow the cpu data port
package soc_pkg;

	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,   // 8 bit access
		SIZE_HALF = 2'd1,   // 16 bit access
		SIZE_WORD = 2'd2    // 32 bit access
	} mem_size_t;

	typedef enum logic [1:0] {
		ARB_IDLE = 2'd0,    // waiting for re/we
		ARB_BUSY = 2'd1,    // strobe, then fetch result
		ARB_ACK  = 2'd2     // done cycle
	} arb_state_t;

	typedef enum logic [1:0] {
		TGT_RAM  = 2'd0,    // boot ram
		TGT_IO   = 2'd1,    // i/o page
		TGT_NONE = 2'd2     // unmapped
	} target_t;

endpackage

// File: hw/lane_steer.sv
// big-endian lane steering, byte offset 0 is bits 31..24
// loads are zero-extended; outputs are meaningless while misaligned
`timescale 1ns/100ps

module lane_steer (
	input  logic [1:0]        addr_lo,
	input  soc_pkg::mem_size_t size,
	input  logic [31:0]       wdata,
	input  logic [31:0]       word_rdata,
	output logic [3:0]        byte_sel,
	output logic [31:0]       lane_wdata,
	output logic [31:0]       load_data,
	output logic              misaligned
);
	import soc_pkg::*;

	always_comb begin
		byte_sel   = 4'b0000;
		lane_wdata = wdata;
		load_data  = word_rdata;
		misaligned = 1'b0;
		case (size)
			SIZE_BYTE: begin
				byte_sel   = 4'b1000 >> addr_lo;   // offset 0 -> msb lane
				lane_wdata = {4{wdata[7:0]}};      // byte in every lane
				case (addr_lo)
					2'd0:    load_data = {24'h0, word_rdata[31:24]};
					2'd1:    load_data = {24'h0, word_rdata[23:16]};
					2'd2:    load_data = {24'h0, word_rdata[15:8]};
					default: load_data = {24'h0, word_rdata[7:0]};
				endcase
			end
			SIZE_HALF: begin
				byte_sel   = addr_lo[1] ? 4'b0011 : 4'b1100;
				lane_wdata = {2{wdata[15:0]}};     // half in both halves
				load_data  = addr_lo[1] ? {16'h0, word_rdata[15:0]}
				                        : {16'h0, word_rdata[31:16]};
				misaligned = addr_lo[0];           // odd address
			end
			SIZE_WORD: begin
				byte_sel   = 4'b1111;
				misaligned = |addr_lo;             // not on a word boundary
			end
			default: begin
				misaligned = 1'b1;                 // undefined size, refuse it
			end
		endcase
	end

endmodule

// File: hw/boot_ram.sv
// dual-port boot ram, 2048 x 32, registered reads on both ports
// data port writes by byte lane and reads the old word on a write
// contents start cleared, there is no reset of the array
`timescale 1ns/100ps
`include "soc_params.svh"

module boot_ram (
	input  logic                clk_50mhz,
	input  logic [`BRAM_AW-1:0] ins_addr,
	input  logic [`BRAM_AW-1:0] data_addr,
	input  logic                data_we,
	input  logic [3:0]          data_byte_sel,
	input  logic [31:0]         data_wdata,
	output logic [31:0]         ins_rdata,
	output logic [31:0]         data_rdata
);
	localparam int DEPTH = 1 << `BRAM_AW;

	logic [31:0] mem [0:DEPTH-1];

	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = 32'h0;            // block ram powers up cleared
		end
	end

	// data port, read/write
	always_ff @(posedge clk_50mhz) begin
		if (data_we) begin
			for (int b = 0; b < 4; b++) begin
				if (data_byte_sel[b]) begin   // sel[3] is bits 31..24
					mem[data_addr][b*8 +: 8] <= data_wdata[b*8 +: 8];
				end
			end
		end
		data_rdata <= mem[data_addr];       // read-before-write
	end

	// instruction port, read only
	always_ff @(posedge clk_50mhz) begin
		ins_rdata <= mem[ins_addr];
	end

endmodule

// File: hw/io_space.sv
// i/o page: leds, synchronized switches, 16 bit display value
// display is scanned digit 0..3, active low drivers and segments
// only word offsets 0..2 are decoded, other offsets read 0
`timescale 1ns/100ps
`include "soc_params.svh"

module io_space (
	input  logic              clk_50mhz,
	input  logic              arst_n,
	input  logic [`IO_AW-1:0] io_addr,
	input  logic              io_re,
	input  logic              io_we,
	input  logic [31:0]       io_wdata,
	input  logic [7:0]        switches,
	output logic [31:0]       io_rdata,
	output logic [7:0]        leds,
	output logic [3:0]        drivers_n,
	output logic [7:0]        segments_n
);
	localparam int SCAN_W = $clog2(`SCAN_DIV);

	logic [15:0]       disp_val;   // four hex digits
	logic [7:0]        sw_meta;    // first sync stage
	logic [7:0]        sw_sync;    // second sync stage
	logic [SCAN_W-1:0] scan_cnt;
	logic [1:0]        digit;      // digit being driven
	logic [3:0]        nibble;

	// hex to segments, a in bit 0
	function automatic logic [6:0] hex7(input logic [3:0] nib);
		case (nib)
			4'h0: hex7 = 7'h3f;
			4'h1: hex7 = 7'h06;
			4'h2: hex7 = 7'h5b;
			4'h3: hex7 = 7'h4f;
			4'h4: hex7 = 7'h66;
			4'h5: hex7 = 7'h6d;
			4'h6: hex7 = 7'h7d;
			4'h7: hex7 = 7'h07;
			4'h8: hex7 = 7'h7f;
			4'h9: hex7 = 7'h6f;
			4'ha: hex7 = 7'h77;
			4'hb: hex7 = 7'h7c;
			4'hc: hex7 = 7'h39;
			4'hd: hex7 = 7'h5e;
			4'he: hex7 = 7'h79;
			default: hex7 = 7'h71;
		endcase
	endfunction

	always_ff @(posedge clk_50mhz or negedge arst_n) begin
		if (!arst_n) begin
			leds     <= 8'h00;
			disp_val <= 16'h0000;
			sw_meta  <= 8'h00;
			sw_sync  <= 8'h00;
		end else begin
			sw_meta <= switches;              // async board inputs
			sw_sync <= sw_meta;
			if (io_we) begin
				case (io_addr)
					`IO_LEDS:    leds     <= io_wdata[7:0];
					`IO_DISPLAY: disp_val <= io_wdata[15:0];
					default:     ;            // switches are read only
				endcase
			end
		end
	end

	// read data lands one cycle after the strobe
	always_ff @(posedge clk_50mhz) begin
		if (io_re) begin
			case (io_addr)
				`IO_LEDS:     io_rdata <= {24'h0, leds};
				`IO_SWITCHES: io_rdata <= {24'h0, sw_sync};
				`IO_DISPLAY:  io_rdata <= {16'h0, disp_val};
				default:      io_rdata <= 32'h0;
			endcase
		end
	end

	assign nibble = disp_val[{digit, 2'b00} +: 4];   // digit k shows nibble k

	always_ff @(posedge clk_50mhz or negedge arst_n) begin
		if (!arst_n) begin
			scan_cnt   <= '0;
			digit      <= 2'd0;
			drivers_n  <= 4'hf;                   // all digits dark
			segments_n <= 8'hff;
		end else begin
			if (scan_cnt == SCAN_W'(`SCAN_DIV - 1)) begin
				scan_cnt <= '0;
				digit    <= digit + 2'd1;
			end else begin
				scan_cnt <= scan_cnt + 1'b1;
			end
			drivers_n  <= ~(4'b0001 << digit);
			segments_n <= {1'b1, ~hex7(nibble)};  // dp kept off
		end
	end

endmodule

// File: hw/mem_arbiter.sv
// data port arbiter: fixed 2 cycle latency for every target and error
// the master holds its request until done; nothing is taken in the done cycle
// instruction port reads the second ram port, done every other cycle
`timescale 1ns/100ps
`include "soc_params.svh"

module mem_arbiter (
	input  logic                clk_50mhz,
	input  logic                arst_n,
	input  logic [31:0]         dmem_addr,
	input  logic                dmem_re,
	input  logic                dmem_we,
	input  logic [31:0]         imem_addr,
	input  logic                imem_re,
	input  logic                misaligned,
	input  logic [31:0]         load_data,
	input  logic [31:0]         lane_wdata,
	input  logic [3:0]          byte_sel,
	input  logic [31:0]         ram_rdata,
	input  logic [31:0]         ram_ins_rdata,
	input  logic [31:0]         io_rdata,
	output logic [31:0]         dmem_rdata,
	output logic                dmem_done,
	output logic                align_error,
	output logic                bus_error,
	output logic [31:0]         imem_data,
	output logic                imem_done,
	output logic                ram_we,
	output logic [3:0]          ram_byte_sel,
	output logic [`BRAM_AW-1:0] ram_addr,
	output logic [`BRAM_AW-1:0] ram_ins_addr,
	output logic                io_re,
	output logic                io_we,
	output logic [`IO_AW-1:0]   io_addr,
	output logic [31:0]         io_wdata,
	output logic [31:0]         word_rdata
);
	import soc_pkg::*;

	arb_state_t state;
	target_t    tgt_dec;     // decode of the live address
	target_t    tgt_q;       // target of the access in flight
	logic       mis_q;
	logic       wr_q;
	logic       issued;      // strobe already sent in ARB_BUSY
	logic       access_ok;
	logic       strobe;
	logic       finish;      // last BUSY cycle, result is ready
	logic       ins_hit_q;   // fetched address was inside ram

	always_comb begin
		if (dmem_addr[31:`BRAM_AW+2] == `RAM_BASE_HI) begin
			tgt_dec = TGT_RAM;
		end else if (dmem_addr[31:8] == `IO_BASE) begin
			tgt_dec = TGT_IO;
		end else begin
			tgt_dec = TGT_NONE;
		end
	end

	always_ff @(posedge clk_50mhz or negedge arst_n) begin
		if (!arst_n) begin
			state  <= ARB_IDLE;
			tgt_q  <= TGT_NONE;
			mis_q  <= 1'b0;
			wr_q   <= 1'b0;
			issued <= 1'b0;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (dmem_re || dmem_we) begin   // edge 0, sample request
						tgt_q  <= tgt_dec;
						mis_q  <= misaligned;
						wr_q   <= dmem_we;
						issued <= 1'b0;
						state  <= ARB_BUSY;
					end
				end
				ARB_BUSY: begin
					issued <= 1'b1;                 // edge 1, access done
					if (issued) begin
						state <= ARB_ACK;           // edge 2
					end
				end
				default: state <= ARB_IDLE;         // ACK lasts one cycle
			endcase
		end
	end

	assign access_ok = (tgt_q != TGT_NONE) && !mis_q;
	assign strobe    = (state == ARB_BUSY) && !issued && access_ok;
	assign finish    = (state == ARB_BUSY) && issued;

	assign ram_we       = strobe && wr_q && (tgt_q == TGT_RAM);
	assign io_we        = strobe && wr_q && (tgt_q == TGT_IO);
	assign io_re        = strobe && !wr_q && (tgt_q == TGT_IO);
	assign ram_byte_sel = byte_sel;
	assign ram_addr     = dmem_addr[`BRAM_AW+1:2];   // held stable by master
	assign io_addr      = dmem_addr[`IO_AW+1:2];
	assign io_wdata     = lane_wdata;
	assign word_rdata   = (tgt_q == TGT_IO) ? io_rdata : ram_rdata;

	assign dmem_done = (state == ARB_ACK);

	always_ff @(posedge clk_50mhz or negedge arst_n) begin
		if (!arst_n) begin
			align_error <= 1'b0;
			bus_error   <= 1'b0;
		end else begin
			align_error <= finish && mis_q;      // alignment wins over decode
			bus_error   <= finish && !mis_q && (tgt_q == TGT_NONE);
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (finish) begin
			dmem_rdata <= (!wr_q && access_ok) ? load_data : 32'h0;
		end
	end

	// instruction side
	assign ram_ins_addr = imem_addr[`BRAM_AW+1:2];

	always_ff @(posedge clk_50mhz or negedge arst_n) begin
		if (!arst_n) begin
			imem_done <= 1'b0;
			ins_hit_q <= 1'b0;
		end else begin
			imem_done <= imem_re && !imem_done;   // low one cycle between fetches
			ins_hit_q <= (imem_addr[31:`BRAM_AW+2] == `RAM_BASE_HI);
		end
	end

	assign imem_data = ins_hit_q ? ram_ins_rdata : 32'h0;

endmodule

// File: hw/soc_memsys.sv
// memory and i/o side of the soc, cpu ports driven from outside
// all blocks run on the rising edge of clk_50mhz
`timescale 1ns/100ps
`include "soc_params.svh"

module soc_memsys (
	input  logic               clk_50mhz,
	input  logic               arst_n,
	input  logic [31:0]        dmem_addr,
	input  logic [31:0]        dmem_wdata,
	input  logic               dmem_re,
	input  logic               dmem_we,
	input  soc_pkg::mem_size_t dmem_size,
	output logic [31:0]        dmem_rdata,
	output logic               dmem_done,
	output logic               align_error,
	output logic               bus_error,
	input  logic [31:0]        imem_addr,
	input  logic               imem_re,
	output logic [31:0]        imem_data,
	output logic               imem_done,
	output logic [7:0]         leds,
	output logic [3:0]         drivers_n,
	output logic [7:0]         segments_n,
	input  logic [7:0]         switches
);
	logic [3:0]          byte_sel;       // lane steer to arbiter
	logic [31:0]         lane_wdata;
	logic [31:0]         load_data;
	logic                misaligned;
	logic [31:0]         word_rdata;     // fetched word back to steer
	logic                ram_we;         // arbiter to/from boot ram
	logic [3:0]          ram_byte_sel;
	logic [`BRAM_AW-1:0] ram_addr;
	logic [`BRAM_AW-1:0] ram_ins_addr;
	logic [31:0]         ram_rdata;
	logic [31:0]         ram_ins_rdata;
	logic                io_re;          // arbiter to/from i/o page
	logic                io_we;
	logic [`IO_AW-1:0]   io_addr;
	logic [31:0]         io_wdata;
	logic [31:0]         io_rdata;

	mem_arbiter u_arbiter (
		.clk_50mhz     (clk_50mhz),
		.arst_n        (arst_n),
		.dmem_addr     (dmem_addr),
		.dmem_re       (dmem_re),
		.dmem_we       (dmem_we),
		.imem_addr     (imem_addr),
		.imem_re       (imem_re),
		.misaligned    (misaligned),
		.load_data     (load_data),
		.lane_wdata    (lane_wdata),
		.byte_sel      (byte_sel),
		.ram_rdata     (ram_rdata),
		.ram_ins_rdata (ram_ins_rdata),
		.io_rdata      (io_rdata),
		.dmem_rdata    (dmem_rdata),
		.dmem_done     (dmem_done),
		.align_error   (align_error),
		.bus_error     (bus_error),
		.imem_data     (imem_data),
		.imem_done     (imem_done),
		.ram_we        (ram_we),
		.ram_byte_sel  (ram_byte_sel),
		.ram_addr      (ram_addr),
		.ram_ins_addr  (ram_ins_addr),
		.io_re         (io_re),
		.io_we         (io_we),
		.io_addr       (io_addr),
		.io_wdata      (io_wdata),
		.word_rdata    (word_rdata)
	);

	lane_steer u_lane_steer (
		.addr_lo    (dmem_addr[1:0]),
		.size       (dmem_size),
		.wdata      (dmem_wdata),
		.word_rdata (word_rdata),
		.byte_sel   (byte_sel),
		.lane_wdata (lane_wdata),
		.load_data  (load_data),
		.misaligned (misaligned)
	);

	boot_ram u_boot_ram (
		.clk_50mhz     (clk_50mhz),
		.ins_addr      (ram_ins_addr),
		.data_addr     (ram_addr),
		.data_we       (ram_we),
		.data_byte_sel (ram_byte_sel),
		.data_wdata    (lane_wdata),     // steered store data
		.ins_rdata     (ram_ins_rdata),
		.data_rdata    (ram_rdata)
	);

	io_space u_io_space (
		.clk_50mhz  (clk_50mhz),
		.arst_n     (arst_n),
		.io_addr    (io_addr),
		.io_re      (io_re),
		.io_we      (io_we),
		.io_wdata   (io_wdata),
		.switches   (switches),
		.io_rdata   (io_rdata),
		.leds       (leds),
		.drivers_n  (drivers_n),
		.segments_n (segments_n)
	);

endmodule

// File: tb/soc_memsys_assert.sv
// concurrent checks on the data and instruction handshakes and the display scan
// disp_ref is loaded by the testbench after every display write
`timescale 1ns/100ps

module soc_memsys_assert (
	input logic       clk_50mhz,
	input logic       arst_n,
	input logic       dmem_re,
	input logic       dmem_we,
	input logic       dmem_done,
	input logic       align_error,
	input logic       bus_error,
	input logic       imem_re,
	input logic       imem_done,
	input logic [7:0] leds,
	input logic [3:0] drivers_n,
	input logic [7:0] segments_n
);
	logic [15:0] disp_ref   = 16'h0000;   // expected display value
	int          fail_count = 0;
	logic        req_q;                    // request seen last edge
	logic        done_q;
	logic        req_start;                // request sampled in idle

	always_ff @(posedge clk_50mhz or negedge arst_n) begin
		if (!arst_n) begin
			req_q  <= 1'b0;
			done_q <= 1'b0;
		end else begin
			req_q  <= dmem_re || dmem_we;
			done_q <= dmem_done;
		end
	end

	assign req_start = (dmem_re || dmem_we) && (!req_q || done_q);

	// common anode codes, dp in bit 7 off
	function automatic logic [7:0] seg_code(input logic [3:0] nib);
		case (nib)
			4'h0: return 8'hc0;
			4'h1: return 8'hf9;
			4'h2: return 8'ha4;
			4'h3: return 8'hb0;
			4'h4: return 8'h99;
			4'h5: return 8'h92;
			4'h6: return 8'h82;
			4'h7: return 8'hf8;
			4'h8: return 8'h80;
			4'h9: return 8'h90;
			4'ha: return 8'h88;
			4'hb: return 8'h83;
			4'hc: return 8'hc6;
			4'hd: return 8'ha1;
			4'he: return 8'h86;
			default: return 8'h8e;
		endcase
	endfunction

	function automatic logic [3:0] lit_nibble(input logic [3:0] drv_n, input logic [15:0] v);
		case (drv_n)
			4'b1110: return v[3:0];
			4'b1101: return v[7:4];
			4'b1011: return v[11:8];
			default: return v[15:12];
		endcase
	endfunction

	a_reset_idle: assert property (@(posedge clk_50mhz) $rose(arst_n) |-> !dmem_done &&
		!imem_done && !align_error && !bus_error && leds == 8'h00 && drivers_n == 4'hf)
		else begin $error("outputs not idle right after reset"); fail_count++; end
	a_done_latency: assert property (@(posedge clk_50mhz) disable iff (!arst_n)
		$past(req_start, 3) |-> dmem_done)
		else begin $error("dmem_done missing 2 cycles after request"); fail_count++; end
	a_done_origin: assert property (@(posedge clk_50mhz) disable iff (!arst_n)
		dmem_done |-> $past(req_start, 3) && (dmem_re || dmem_we))
		else begin $error("dmem_done without a matching request"); fail_count++; end
	a_done_single: assert property (@(posedge clk_50mhz) disable iff (!arst_n)
		dmem_done |=> !dmem_done)
		else begin $error("dmem_done longer than one cycle"); fail_count++; end
	a_err_done: assert property (@(posedge clk_50mhz) disable iff (!arst_n)
		(align_error || bus_error) |-> dmem_done)
		else begin $error("error flag outside the done cycle"); fail_count++; end
	a_imem_pulse: assert property (@(posedge clk_50mhz) disable iff (!arst_n)
		(imem_re && !imem_done) |=> imem_done)
		else begin $error("imem_done missing after fetch request"); fail_count++; end
	a_imem_single: assert property (@(posedge clk_50mhz) disable iff (!arst_n)
		imem_done |=> !imem_done)
		else begin $error("imem_done longer than one cycle"); fail_count++; end
	a_segments: assert property (@(posedge clk_50mhz) disable iff (!arst_n)
		(drivers_n != 4'hf && !dmem_re && !dmem_we) |->
		$onehot(~drivers_n) && segments_n == seg_code(lit_nibble(drivers_n, disp_ref)))
		else begin $error("segments do not match the lit digit"); fail_count++; end

endmodule

// File: tb/soc_memsys_tb.sv
// testbench for the memory system driving the cpu data and instruction ports
// checks are immediate assertions here plus the bound concurrent set in u_assert
`timescale 1ns/100ps
`include "soc_params.svh"

module soc_memsys_tb;
	import soc_pkg::*;

	localparam int TIMEOUT = 20;          // cycles allowed per handshake

	logic        clk_50mhz;
	logic        arst_n;
	logic [31:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic        dmem_re;
	logic        dmem_we;
	mem_size_t   dmem_size;
	logic [31:0] dmem_rdata;
	logic        dmem_done;
	logic        align_error;
	logic        bus_error;
	logic [31:0] imem_addr;
	logic        imem_re;
	logic [31:0] imem_data;
	logic        imem_done;
	logic [7:0]  leds;
	logic [3:0]  drivers_n;
	logic [7:0]  segments_n;
	logic [7:0]  switches;

	logic [31:0] ref_mem [0:(1 << `BRAM_AW) - 1];   // predicted ram contents
	logic [31:0] lfsr;
	logic [31:0] addr_log [$];                      // word addresses written
	int          errors;
	int          checks;

	soc_memsys dut (.*);

	bind soc_memsys soc_memsys_assert u_assert (
		.clk_50mhz (clk_50mhz), .arst_n (arst_n), .dmem_re (dmem_re), .dmem_we (dmem_we),
		.dmem_done (dmem_done), .align_error (align_error), .bus_error (bus_error),
		.imem_re (imem_re), .imem_done (imem_done), .leds (leds),
		.drivers_n (drivers_n), .segments_n (segments_n)
	);

	initial clk_50mhz = 1'b0;
	always #10 clk_50mhz = ~clk_50mhz;   // 50 MHz

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);       // one step per bit
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// big-endian model where offset 0 is bits 31..24
	task automatic ref_store(input logic [31:0] a, input logic [31:0] d, input mem_size_t sz);
		int lane;
		lane = 3 - int'(a[1:0]);
		case (sz)
			SIZE_BYTE: ref_mem[a[`BRAM_AW+1:2]][lane*8 +: 8] = d[7:0];
			SIZE_HALF: ref_mem[a[`BRAM_AW+1:2]][(lane/2)*16 +: 16] = d[15:0];
			default:   ref_mem[a[`BRAM_AW+1:2]] = d;
		endcase
	endtask

	function automatic logic [31:0] ref_load(input logic [31:0] a, input mem_size_t sz);
		logic [31:0] w;
		int          lane;
		w    = ref_mem[a[`BRAM_AW+1:2]];
		lane = 3 - int'(a[1:0]);
		case (sz)
			SIZE_BYTE: return {24'h0, w[lane*8 +: 8]};        // zero-extended
			SIZE_HALF: return {16'h0, w[(lane/2)*16 +: 16]};
			default:   return w;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("Error: time %0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flags(input logic ae, input logic be, input logic exp_ae,
	                           input logic exp_be);
		check_value("align_error", {31'h0, ae}, {31'h0, exp_ae});
		check_value("bus_error", {31'h0, be}, {31'h0, exp_be});
	endtask

	task automatic timeout_abort(input string what);
		$display("time %0t: %s", $time, what);
		$display("Simulation failed");
		$finish;
	endtask

	// one data access held until done and dropped on the next edge
	task automatic dmem_access(input logic wr, input logic [31:0] a, input logic [31:0] d,
	                           input mem_size_t sz, output logic [31:0] rdata,
	                           output logic ae, output logic be);
		int wait_cnt;
		bit seen;
		wait_cnt = 0;
		seen     = 1'b0;
		@(posedge clk_50mhz);
		dmem_addr  <= a;
		dmem_wdata <= d;
		dmem_size  <= sz;
		dmem_we    <= wr;
		dmem_re    <= !wr;
		while (!seen && wait_cnt < TIMEOUT) begin
			@(negedge clk_50mhz);         // mid cycle when outputs are settled
			seen = dmem_done;
			wait_cnt++;
		end
		if (!seen) begin
			timeout_abort("dmem_done did not arrive within the timeout");
		end else begin
			rdata = dmem_rdata;
			ae    = align_error;
			be    = bus_error;
			@(posedge clk_50mhz);
			dmem_re <= 1'b0;
			dmem_we <= 1'b0;
		end
	endtask

	task automatic dmem_write(input logic [31:0] a, input logic [31:0] d, input mem_size_t sz,
	                          output logic ae, output logic be);
		logic [31:0] unused;
		dmem_access(1'b1, a, d, sz, unused, ae, be);
	endtask

	task automatic dmem_read(input logic [31:0] a, input mem_size_t sz,
	                         output logic [31:0] d, output logic ae, output logic be);
		dmem_access(1'b0, a, 32'h0, sz, d, ae, be);
	endtask

	task automatic imem_read(input logic [31:0] a, output logic [31:0] d);
		int wait_cnt;
		bit seen;
		wait_cnt = 0;
		seen     = 1'b0;
		@(posedge clk_50mhz);
		imem_addr <= a;
		imem_re   <= 1'b1;
		while (!seen && wait_cnt < TIMEOUT) begin
			@(negedge clk_50mhz);
			seen = imem_done;
			wait_cnt++;
		end
		if (!seen) begin
			timeout_abort("imem_done did not arrive within the timeout");
		end else begin
			d = imem_data;
			@(posedge clk_50mhz);
			imem_re <= 1'b0;
		end
	endtask

	initial begin
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] got;
		logic        ae;
		logic        be;
		errors     = 0;
		checks     = 0;
		lfsr       = 32'h06386cf1;
		arst_n     = 1'b0;
		dmem_addr  = 32'h0;
		dmem_wdata = 32'h0;
		dmem_re    = 1'b0;
		dmem_we    = 1'b0;
		dmem_size  = SIZE_WORD;
		imem_addr  = 32'h0;
		imem_re    = 1'b0;
		switches   = 8'h00;
		for (int i = 0; i < (1 << `BRAM_AW); i++) begin
			ref_mem[i] = 32'h0;           // ram starts cleared
		end
		repeat (3) @(posedge clk_50mhz);
		arst_n <= 1'b1;

		// random words each read straight back
		for (int i = 0; i < 24; i++) begin
			a = rand_bits(`BRAM_AW) << 2;
			d = rand_bits(32);
			dmem_write(a, d, SIZE_WORD, ae, be);
			ref_store(a, d, SIZE_WORD);
			addr_log.push_back(a);
			dmem_read(a, SIZE_WORD, got, ae, be);
			check_value("dmem_rdata", got, ref_load(a, SIZE_WORD));
			check_flags(ae, be, 1'b0, 1'b0);
		end

		// byte and halfword lanes
		a = 32'h0000_0100;
		dmem_write(a, 32'h1122_3344, SIZE_WORD, ae, be);
		ref_store(a, 32'h1122_3344, SIZE_WORD);
		for (int off = 0; off < 4; off++) begin
			d = rand_bits(32);            // upper bits must be ignored
			dmem_write(a + off, d, SIZE_BYTE, ae, be);
			ref_store(a + off, d, SIZE_BYTE);
			dmem_read(a, SIZE_WORD, got, ae, be);
			check_value("dmem_rdata", got, ref_load(a, SIZE_WORD));
			for (int k = 0; k < 4; k++) begin
				dmem_read(a + k, SIZE_BYTE, got, ae, be);
				check_value("dmem_rdata", got, ref_load(a + k, SIZE_BYTE));
			end
		end
		for (int off = 0; off < 4; off += 2) begin
			d = rand_bits(32);
			dmem_write(a + off, d, SIZE_HALF, ae, be);
			ref_store(a + off, d, SIZE_HALF);
			for (int k = 0; k < 4; k += 2) begin
				dmem_read(a + k, SIZE_HALF, got, ae, be);
				check_value("dmem_rdata", got, ref_load(a + k, SIZE_HALF));
			end
		end
		addr_log.push_back(a);

		// instruction port sees data port writes
		foreach (addr_log[i]) begin
			imem_read(addr_log[i], got);
			check_value("imem_data", got, ref_load(addr_log[i], SIZE_WORD));
		end
		imem_read(32'h8000_0100, got);
		check_value("imem_data", got, 32'h0);   // outside ram on the index of 0x100
		@(posedge clk_50mhz);
		imem_re <= 1'b1;                         // held so done alternates
		repeat (6) @(posedge clk_50mhz);
		imem_re <= 1'b0;

		// i/o page
		dmem_write(32'h8000_0000, 32'h0000_00a5, SIZE_WORD, ae, be);
		@(negedge clk_50mhz);
		check_value("leds", {24'h0, leds}, 32'h0000_00a5);
		dmem_read(32'h8000_0000, SIZE_WORD, got, ae, be);
		check_value("dmem_rdata", got, 32'h0000_00a5);
		d = rand_bits(8);
		@(posedge clk_50mhz);
		switches <= d[7:0];
		repeat (3) @(posedge clk_50mhz);
		dmem_read(32'h8000_0004, SIZE_WORD, got, ae, be);
		check_value("dmem_rdata", got, {24'h0, d[7:0]});
		for (int n = 0; n < 2; n++) begin
			d = rand_bits(16);
			dmem_write(32'h8000_0008, d, SIZE_WORD, ae, be);
			dut.u_assert.disp_ref <= d[15:0];    // same edge as the request drop
			repeat (5 * `SCAN_DIV) @(posedge clk_50mhz);
		end

		// misaligned and unmapped accesses
		a = 32'h0000_0200;
		d = rand_bits(32);
		dmem_write(a, d, SIZE_WORD, ae, be);
		ref_store(a, d, SIZE_WORD);
		dmem_write(a + 2, ~d, SIZE_WORD, ae, be);
		check_flags(ae, be, 1'b1, 1'b0);
		dmem_write(a + 1, ~d, SIZE_HALF, ae, be);
		check_flags(ae, be, 1'b1, 1'b0);
		dmem_read(a + 3, SIZE_HALF, got, ae, be);
		check_value("dmem_rdata", got, 32'h0);
		check_flags(ae, be, 1'b1, 1'b0);
		dmem_write(32'h4000_0000, ~d, SIZE_WORD, ae, be);
		check_flags(ae, be, 1'b0, 1'b1);
		dmem_read(32'h0000_2200, SIZE_WORD, got, ae, be);   // same ram index as a
		check_value("dmem_rdata", got, 32'h0);
		check_flags(ae, be, 1'b0, 1'b1);
		dmem_read(a, SIZE_WORD, got, ae, be);
		check_value("dmem_rdata", got, ref_load(a, SIZE_WORD));
		dmem_read(32'h0000_0000, SIZE_WORD, got, ae, be);   // alias of 0x4000_0000
		check_value("dmem_rdata", got, ref_load(32'h0000_0000, SIZE_WORD));

		repeat (4) @(posedge clk_50mhz);
		$display("checks %0d, check errors %0d, assertion failures %0d",
		         checks, errors, dut.u_assert.fail_count);
		if (errors == 0 && dut.u_assert.fail_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: files.f
+incdir+hw
hw/soc_pkg.sv
hw/lane_steer.sv
hw/boot_ram.sv
hw/io_space.sv
hw/mem_arbiter.sv
hw/soc_memsys.sv
tb/soc_memsys_assert.sv
tb/soc_memsys_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the memory system testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module soc_memsys_tb -f files.f \
	--Mdir obj_dir -o soc_memsys_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/soc_memsys_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
	exit 1
fi
exit 0
